// File: hw/cluster_ctrl_pkg.sv
//////////////////////////////////////////////////
// Cluster control types: cluster ids and the
// per-cluster fetch-enable mask.
//////////////////////////////////////////////////

`default_nettype none

`include "mbox_defines.svh"

package cluster_ctrl_pkg;

  // same width as the id field of a message
  typedef logic [5:0] cluster_id_t;

  // one fetch-enable bit per cluster
  typedef logic [`N_CLUSTERS-1:0] cluster_mask_t;

endpackage

`default_nettype wire

// File: hw/mbox_defines.svh
//////////////////////////////////////////////////
// Sizing macros for the host-to-device mailbox.
// Include this file wherever mailbox depth, word
// width or cluster count is needed.
//////////////////////////////////////////////////

`ifndef MBOX_DEFINES_SVH
`define MBOX_DEFINES_SVH

// number of words the mailbox FIFO can hold
`define MBOX_DEPTH 8

// mailbox word width in bits
`define MBOX_WORD_W 32

// host address width in bits
`define MBOX_ADDR_W 32

// host address of the mailbox data register
`define MBOX_BASE_ADDR 32'h0000_1000

// clusters under fetch-enable control
`define N_CLUSTERS 4

`endif

// File: hw/mbox_dispatch.sv
//////////////////////////////////////////////////
// Mailbox consumer. Pops words in order, holds
// data words for the device until acknowledged and
// applies fetch-enable commands to the clusters.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mbox_defines.svh"

module mbox_dispatch (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  mbox_msg_pkg::mbox_word_u      head_word_i,
  input  logic                          empty_i,
  input  logic                          dev_ack_i,
  output logic                          pop_o,
  output mbox_msg_pkg::mbox_word_u      dev_data_o,
  output logic                          dev_valid_o,
  output logic                          mbox_irq_o,
  output cluster_ctrl_pkg::cluster_mask_t cl_fetch_en_o
);
  import mbox_msg_pkg::*;
  import cluster_ctrl_pkg::*;

  mbox_word_u    data_q;
  logic          valid_q;
  cluster_mask_t fetch_en_q;
  mbox_cmd_e     cmd;
  cluster_id_t   cl_id;
  logic          is_fetch;

  // head word read as a message
  assign cmd      = head_word_i.msg.cmd;
  assign cl_id    = head_word_i.msg.cluster_id;
  assign is_fetch = (cmd == CMD_FETCH_SET) || (cmd == CMD_FETCH_CLR);

  // only take a word when nothing is waiting for the device
  assign pop_o = !empty_i && !valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (pop_o && !is_fetch) begin
      valid_q <= 1'b1;
    end else if (dev_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  // data and reserved commands go out as raw words
  always_ff @(posedge clk_i) begin
    if (pop_o && !is_fetch) begin
      data_q <= head_word_i;
    end
  end

  // ids at or above the cluster count match no bit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_en_q <= '0;
    end else if (pop_o && is_fetch) begin
      for (int i = 0; i < `N_CLUSTERS; i++) begin
        if (cl_id == cluster_id_t'(i)) begin
          fetch_en_q[i] <= (cmd == CMD_FETCH_SET);
        end
      end
    end
  end

  assign dev_data_o    = data_q;
  assign dev_valid_o   = valid_q;
  assign mbox_irq_o    = valid_q;
  assign cl_fetch_en_o = fetch_en_q;

  a_ack_when_valid : assert property (
    @(posedge clk_i) disable iff (reset_i)
    dev_ack_i |-> dev_valid_o
  ) else $error("device ack without a pending mailbox word");

endmodule

`default_nettype wire

// File: hw/mbox_fifo.sv
//////////////////////////////////////////////////
// Circular word buffer between the host port and
// the dispatcher. Push and pop may happen in the
// same cycle; the host port guards against overflow.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mbox_defines.svh"

module mbox_fifo (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             push_i,
  input  mbox_msg_pkg::mbox_word_u         push_word_i,
  input  logic                             pop_i,
  output mbox_msg_pkg::mbox_word_u         head_word_o,
  output logic                             empty_o,
  output logic [$clog2(`MBOX_DEPTH+1)-1:0] count_o
);
  import mbox_msg_pkg::*;

  localparam int unsigned PTR_W = $clog2(`MBOX_DEPTH);
  localparam int unsigned CNT_W = $clog2(`MBOX_DEPTH + 1);

  mbox_word_u       mem_q [`MBOX_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;

  assign full = (count_q == CNT_W'(`MBOX_DEPTH));

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_word_i;
    end
  end

  // pointers wrap at the last entry
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`MBOX_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`MBOX_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_word_o = mem_q[rd_ptr_q];
  assign empty_o     = (count_q == '0);
  assign count_o     = count_q;

  // the host port must have counted the word in flight
  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(push_i && full)
  ) else $error("push into a full mailbox FIFO");

  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(pop_i && empty_o)
  ) else $error("pop from an empty mailbox FIFO");

endmodule

`default_nettype wire

// File: hw/mbox_host_port.sv
//////////////////////////////////////////////////
// Host write port of the mailbox. Decodes each
// host write, drops bad addresses and writes that
// would overflow, and registers the push.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mbox_defines.svh"

module mbox_host_port (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             host_wr_i,
  input  logic [`MBOX_ADDR_W-1:0]          host_addr_i,
  input  mbox_msg_pkg::mbox_word_u         host_wdata_i,
  input  logic [$clog2(`MBOX_DEPTH+1)-1:0] count_i,
  output logic                             push_o,
  output mbox_msg_pkg::mbox_word_u         push_word_o,
  output logic                             host_full_o,
  output logic                             host_err_o
);
  import mbox_msg_pkg::*;

  localparam int unsigned CNT_W = $clog2(`MBOX_DEPTH + 1);

  logic [CNT_W-1:0] level;
  logic             addr_hit;
  logic             accept;
  logic             push_q;
  logic             err_q;
  mbox_word_u       word_q;

  // occupancy once the registered word lands
  assign level = count_i + CNT_W'(push_q);

  assign addr_hit    = (host_addr_i == `MBOX_BASE_ADDR);
  assign host_full_o = (level >= CNT_W'(`MBOX_DEPTH));
  assign accept      = host_wr_i && addr_hit && !host_full_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      push_q <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      push_q <= accept;
      // wrong address or no room
      err_q  <= host_wr_i && !accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_q <= host_wdata_i;
    end
  end

  assign push_o      = push_q;
  assign push_word_o = word_q;
  assign host_err_o  = err_q;

  a_push_not_err : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(push_o && host_err_o)
  ) else $error("push and error pulse in the same cycle");

endmodule

`default_nettype wire

// File: hw/mbox_msg_pkg.sv
//////////////////////////////////////////////////
// Mailbox message format: command codes, the
// message layout and the word union that lets a
// word be read as raw data or as a message.
//////////////////////////////////////////////////

`default_nettype none

`include "mbox_defines.svh"

package mbox_msg_pkg;

  // command in the upper two bits of a word
  typedef enum logic [1:0] {
    CMD_DATA      = 2'd0,
    CMD_FETCH_SET = 2'd1,
    CMD_FETCH_CLR = 2'd2,
    // delivered to the device like data
    CMD_RSVD      = 2'd3
  } mbox_cmd_e;

  // message view, msb first
  typedef struct packed {
    mbox_cmd_e   cmd;
    logic [5:0]  cluster_id;
    logic [23:0] payload;
  } mbox_msg_t;

  // one mailbox word, two ways to look at it
  typedef union packed {
    logic [`MBOX_WORD_W-1:0] raw;
    mbox_msg_t               msg;
  } mbox_word_u;

endpackage

`default_nettype wire

// File: hw/mbox_top.sv
//////////////////////////////////////////////////
// Host-to-device mailbox with cluster fetch-enable
// control. Host port, word FIFO and dispatcher in
// a chain; three cycles from write to output.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mbox_defines.svh"

module mbox_top (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            host_wr_i,
  input  logic [`MBOX_ADDR_W-1:0]         host_addr_i,
  input  mbox_msg_pkg::mbox_word_u        host_wdata_i,
  input  logic                            dev_ack_i,
  output logic                            host_full_o,
  output logic                            host_err_o,
  output mbox_msg_pkg::mbox_word_u        dev_data_o,
  output logic                            dev_valid_o,
  output logic                            mbox_irq_o,
  output cluster_ctrl_pkg::cluster_mask_t cl_fetch_en_o
);
  import mbox_msg_pkg::*;

  logic                             push;
  mbox_word_u                       push_word;
  logic [$clog2(`MBOX_DEPTH+1)-1:0] count;
  mbox_word_u                       head_word;
  logic                             empty;
  logic                             pop;

  mbox_host_port i_host_port (
    .clk_i,
    .reset_i,
    .host_wr_i,
    .host_addr_i,
    .host_wdata_i,
    .count_i      (count),
    .push_o       (push),
    .push_word_o  (push_word),
    .host_full_o,
    .host_err_o
  );

  mbox_fifo i_fifo (
    .clk_i,
    .reset_i,
    .push_i       (push),
    .push_word_i  (push_word),
    .pop_i        (pop),
    .head_word_o  (head_word),
    .empty_o      (empty),
    .count_o      (count)
  );

  mbox_dispatch i_dispatch (
    .clk_i,
    .reset_i,
    .head_word_i  (head_word),
    .empty_i      (empty),
    .dev_ack_i,
    .pop_o        (pop),
    .dev_data_o,
    .dev_valid_o,
    .mbox_irq_o,
    .cl_fetch_en_o
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the mailbox testbench with Verilator and run it.
# Exit status is 0 only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module mbox_tb \
  -Mdir obj_dir -o mbox_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/mbox_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^RESULT: PASS$'; then
  exit 0
fi
echo "pass message not found"
exit 1

// File: verif/mbox_tb.sv
//////////////////////////////////////////////////
// Testbench for the host-to-device mailbox. Applies
// a table of host write sequences and checks the
// device side and fetch mask against a model.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mbox_defines.svh"

module mbox_tb;
  import mbox_msg_pkg::*;
  import cluster_ctrl_pkg::*;

  localparam int N_ROWS          = 12;
  localparam int WATCHDOG_CYCLES = N_ROWS * 40 + 200;

  // one test is n_wr writes of one kind and then hold cycles without ack
  typedef struct packed {
    logic [31:0] addr;
    mbox_cmd_e   cmd;
    logic [5:0]  cl_id;
    logic [7:0]  n_wr;
    logic [7:0]  hold;
    logic [7:0]  exp_err;
  } row_t;

  logic                    clk_i;
  logic                    reset_i;
  logic                    host_wr_i;
  logic [`MBOX_ADDR_W-1:0] host_addr_i;
  mbox_word_u              host_wdata_i;
  logic                    dev_ack_i;
  logic                    host_full_o;
  logic                    host_err_o;
  mbox_word_u              dev_data_o;
  logic                    dev_valid_o;
  logic                    mbox_irq_o;
  cluster_mask_t           cl_fetch_en_o;

  row_t          rows [N_ROWS];
  string         names [N_ROWS];
  int            row_cnt;
  // model queues of words behind the dispatcher and words due at the device
  logic [31:0]   pend_q [$];
  logic [31:0]   exp_data_q [$];
  logic          held;
  cluster_mask_t exp_mask;
  logic [31:0]   rng;
  int            checks;
  int            errors;

  mbox_top i_dut (
    .clk_i,
    .reset_i,
    .host_wr_i,
    .host_addr_i,
    .host_wdata_i,
    .dev_ack_i,
    .host_full_o,
    .host_err_o,
    .dev_data_o,
    .dev_valid_o,
    .mbox_irq_o,
    .cl_fetch_en_o
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic add_row(input string name, input logic [31:0] addr, input mbox_cmd_e cmd,
                         input logic [5:0] id, input int n, input int hold, input int err);
    names[row_cnt]        = name;
    rows[row_cnt].addr    = addr;
    rows[row_cnt].cmd     = cmd;
    rows[row_cnt].cl_id   = id;
    rows[row_cnt].n_wr    = 8'(n);
    rows[row_cnt].hold    = 8'(hold);
    rows[row_cnt].exp_err = 8'(err);
    row_cnt++;
  endtask

  // dispatcher model is free whenever no data word waits for an ack
  function automatic void dispatch_pending();
    mbox_word_u    w;
    cluster_mask_t sel;
    while (!held && pend_q.size() > 0) begin
      w.raw = pend_q.pop_front();
      if (w.msg.cmd == CMD_FETCH_SET || w.msg.cmd == CMD_FETCH_CLR) begin
        if (w.msg.cluster_id < 6'(`N_CLUSTERS)) begin
          sel      = cluster_mask_t'(1) << w.msg.cluster_id;
          exp_mask = (w.msg.cmd == CMD_FETCH_SET) ? (exp_mask | sel) : (exp_mask & ~sel);
        end
      end else begin
        exp_data_q.push_back(w.raw);
        held = 1'b1;
      end
    end
  endfunction

  // returns the expected error as eight words fit behind the held one
  function automatic logic predict_write(input logic [31:0] addr, input mbox_word_u word);
    if (addr != `MBOX_BASE_ADDR || pend_q.size() >= `MBOX_DEPTH) begin
      return 1'b1;
    end
    pend_q.push_back(word.raw);
    dispatch_pending();
    return 1'b0;
  endfunction

  task automatic host_write(input logic [31:0] addr, input mbox_word_u word,
                            output logic err_seen);
    logic exp_err;
    compare_value("host_full_o", 32'(pend_q.size() >= `MBOX_DEPTH), 32'(host_full_o));
    exp_err      = predict_write(addr, word);
    host_wr_i    = 1'b1;
    host_addr_i  = addr;
    host_wdata_i = word;
    @(negedge clk_i);
    host_wr_i = 1'b0;
    err_seen  = host_err_o;
    compare_value("host_err_o", 32'(exp_err), 32'(host_err_o));
    // error is a one-cycle pulse
    @(negedge clk_i);
    compare_value("host_err_o", 32'd0, 32'(host_err_o));
  endtask

  // caller makes sure a data word is expected
  task automatic match_head_word();
    compare_value("dev_data_o", exp_data_q[0], dev_data_o.raw);
    compare_value("mbox_irq_o", 32'd1, 32'(mbox_irq_o));
  endtask

  task automatic drain_and_ack(input int hold);
    int waited;
    // under back-pressure the held word must stay put
    repeat (hold) begin
      @(negedge clk_i);
      compare_value("dev_valid_o", 32'(exp_data_q.size() > 0), 32'(dev_valid_o));
      if (dev_valid_o && exp_data_q.size() > 0) begin
        match_head_word();
      end
    end
    while (exp_data_q.size() > 0) begin
      waited = 0;
      while (!dev_valid_o && waited < 20) begin
        @(negedge clk_i);
        waited++;
      end
      checks++;
      assert (dev_valid_o) else begin
        $display("error at %0t ns: expected data word did not arrive in 20 cycles", $time);
        errors++;
      end
      if (dev_valid_o) begin
        match_head_word();
        dev_ack_i = 1'b1;
        @(negedge clk_i);
        dev_ack_i = 1'b0;
      end
      exp_data_q.pop_front();
      held = 1'b0;
      dispatch_pending();
    end
  endtask

  task automatic settle_idle();
    // queued fetch commands drain one per cycle
    repeat (`MBOX_DEPTH + 4) begin
      @(negedge clk_i);
      compare_value("dev_valid_o", 32'd0, 32'(dev_valid_o));
    end
    compare_value("cl_fetch_en_o", 32'(exp_mask), 32'(cl_fetch_en_o));
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : main
    row_t       row;
    mbox_word_u word;
    logic       err_seen;
    int         err_cnt;
    int         errors_before;
    int         failed_tests;

    reset_i      = 1'b1;
    host_wr_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    dev_ack_i    = 1'b0;
    rng          = 32'h3029_232d;
    held         = 1'b0;
    exp_mask     = '0;
    checks       = 0;
    errors       = 0;
    failed_tests = 0;
    row_cnt      = 0;

    add_row("data in order", `MBOX_BASE_ADDR, CMD_DATA, 6'd0, 6, 3, 0);
    add_row("fetch set cluster 0", `MBOX_BASE_ADDR, CMD_FETCH_SET, 6'd0, 1, 0, 0);
    add_row("fetch set cluster 2", `MBOX_BASE_ADDR, CMD_FETCH_SET, 6'd2, 1, 0, 0);
    add_row("fetch set cluster 3", `MBOX_BASE_ADDR, CMD_FETCH_SET, 6'd3, 1, 0, 0);
    add_row("fetch clear cluster 0", `MBOX_BASE_ADDR, CMD_FETCH_CLR, 6'd0, 1, 0, 0);
    add_row("fetch set cluster 4", `MBOX_BASE_ADDR, CMD_FETCH_SET, 6'd4, 1, 0, 0);
    add_row("fetch clear cluster 63", `MBOX_BASE_ADDR, CMD_FETCH_CLR, 6'd63, 1, 0, 0);
    add_row("reserved command as data", `MBOX_BASE_ADDR, CMD_RSVD, 6'd5, 2, 0, 0);
    add_row("data to wrong address", `MBOX_BASE_ADDR + 32'h4, CMD_DATA, 6'd0, 3, 0, 3);
    add_row("fetch to address zero", 32'h0, CMD_FETCH_SET, 6'd1, 1, 0, 1);
    add_row("overflow under back-pressure", `MBOX_BASE_ADDR, CMD_DATA, 6'd0, 10, 30, 1);
    add_row("data after overflow", `MBOX_BASE_ADDR, CMD_DATA, 6'd0, 3, 0, 0);

    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    compare_value("dev_valid_o", 32'd0, 32'(dev_valid_o));
    compare_value("mbox_irq_o", 32'd0, 32'(mbox_irq_o));
    compare_value("host_err_o", 32'd0, 32'(host_err_o));
    compare_value("host_full_o", 32'd0, 32'(host_full_o));
    compare_value("cl_fetch_en_o", 32'd0, 32'(cl_fetch_en_o));
    if (errors != 0) begin
      failed_tests++;
    end
    $display("test 0 reset state: %s", (errors == 0) ? "ok" : "failed");

    for (int r = 0; r < N_ROWS; r++) begin
      row           = rows[r];
      errors_before = errors;
      err_cnt       = 0;
      for (int k = 0; k < int'(row.n_wr); k++) begin
        rng                 = xorshift32(rng);
        word.msg.cmd        = row.cmd;
        word.msg.cluster_id = row.cl_id;
        word.msg.payload    = rng[23:0];
        host_write(row.addr, word, err_seen);
        if (err_seen) begin
          err_cnt++;
        end
      end
      compare_value("host_err_o pulses", 32'(row.exp_err), 32'(err_cnt));
      drain_and_ack(int'(row.hold));
      settle_idle();
      if (errors != errors_before) begin
        failed_tests++;
      end
      $display("test %0d %s: %s", r + 1, names[r], (errors == errors_before) ? "ok" : "failed");
    end

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             N_ROWS + 1, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/mbox_msg_pkg.sv
hw/cluster_ctrl_pkg.sv
hw/mbox_host_port.sv
hw/mbox_fifo.sv
hw/mbox_dispatch.sv
hw/mbox_top.sv
verif/mbox_tb.sv
